/* Makefile */
SIM = obj_dir/Vllc_hit_miss_tb

.PHONY: all run lint clean

all: run

$(SIM): project.f verilog/*.sv test/*.sv
	verilator --binary --assert -f project.f --top-module llc_hit_miss_tb -o Vllc_hit_miss_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "TEST FAILED" sim.log

lint:
	verilator --lint-only --timing --assert -f project.f --top-module llc_hit_miss_tb

clean:
	rm -rf obj_dir sim.log

/* project.f */
verilog/llc_pkg.sv
verilog/llc_tag_store.sv
verilog/llc_lock_table.sv
verilog/llc_hit_miss.sv
test/llc_hit_miss_checker.sv
test/llc_hit_miss_tb.sv

/* test/llc_hit_miss_checker.sv */
module llc_hit_miss_checker (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            desc_ready_i,
  input  logic            init_done_i,
  input  logic            hit_valid_i,
  input  logic            hit_ready_i,
  input  logic            miss_valid_i,
  input  logic            miss_ready_i,
  input  llc_pkg::addr_t  out_addr_i,
  input  logic            out_rw_i,
  input  llc_pkg::id_t    out_id_i,
  input  llc_pkg::way_t   out_way_i,
  input  logic            out_evict_i,
  input  llc_pkg::tag_t   out_evict_tag_i
);
  import llc_pkg::*;

  // all shared output fields in one word
  logic [ADDR_W+ID_W+NUM_WAYS+TAG_W+1:0] out_fields;

  assign out_fields = {out_addr_i, out_rw_i, out_id_i, out_way_i, out_evict_i, out_evict_tag_i};

  //////////////////////////////
  // output protocol
  //////////////////////////////

  a_one_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(hit_valid_i && miss_valid_i))
    else $error("hit_valid_o and miss_valid_o are high together");

  a_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_valid_i || miss_valid_i) |-> $onehot(out_way_i))
    else $error("out_way_o is not one-hot while a valid is high");

  // back-pressure holds valid and every field
  a_hit_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (hit_valid_i && !hit_ready_i) |=> (hit_valid_i && $stable(out_fields)))
    else $error("hit output changed while hit_ready_i was low");

  a_miss_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (miss_valid_i && !miss_ready_i) |=> (miss_valid_i && $stable(out_fields)))
    else $error("miss output changed while miss_ready_i was low");

  // no descriptor enters during the clear sweep
  a_ready_init: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    desc_ready_i |-> init_done_i)
    else $error("desc_ready_o is high before init_done_o");

endmodule

bind llc_hit_miss llc_hit_miss_checker u_checker (
  .clk_i           ( clk_i           ),
  .rst_n_i         ( rst_n_i         ),
  .desc_ready_i    ( desc_ready_o    ),
  .init_done_i     ( init_done_o     ),
  .hit_valid_i     ( hit_valid_o     ),
  .hit_ready_i     ( hit_ready_i     ),
  .miss_valid_i    ( miss_valid_o    ),
  .miss_ready_i    ( miss_ready_i    ),
  .out_addr_i      ( out_addr_o      ),
  .out_rw_i        ( out_rw_o        ),
  .out_id_i        ( out_id_o        ),
  .out_way_i       ( out_way_o       ),
  .out_evict_i     ( out_evict_o     ),
  .out_evict_tag_i ( out_evict_tag_o )
);

/* test/llc_hit_miss_tb.sv */
module llc_hit_miss_tb;
  import llc_pkg::*;

  // cycles any single wait may take
  localparam int TIMEOUT    = 400;
  localparam int RAND_DESCS = 80;

  logic   clk_i;
  logic   rst_n_i;
  addr_t  desc_addr_i;
  logic   desc_rw_i;
  id_t    desc_id_i;
  logic   desc_valid_i;
  logic   desc_ready_o;
  addr_t  out_addr_o;
  logic   out_rw_o;
  id_t    out_id_o;
  way_t   out_way_o;
  logic   out_evict_o;
  tag_t   out_evict_tag_o;
  logic   hit_valid_o;
  logic   hit_ready_i;
  logic   miss_valid_o;
  logic   miss_ready_i;
  index_t unlock_index_i;
  way_t   unlock_way_i;
  logic   unlock_valid_i;
  logic   init_done_o;

  int seed = 32'h3d70_8b0d;
  int mismatch_cnt;
  int fail_cnt;
  // accepted descriptors versus finished output transfers
  int accepted;
  int done_cnt;
  // unlocks the directed tests allow, and the random gap before the next one
  int unlock_budget;
  int unlock_wait;
  logic auto_unlock;
  logic rand_mode;
  id_t  next_id;

  // expected transfer {addr, rw, id, hit, way, evict, evict tag}
  logic [32:0] exp_q [$];
  // lines locked downstream {index, way}, oldest first
  logic [INDEX_W+NUM_WAYS-1:0] lock_q [$];

  // last transfer seen at the output
  logic last_hit;
  way_t last_way;
  logic last_evict;
  tag_t last_evict_tag;

  // mirror of the tag arrays
  logic m_valid [NUM_SETS][NUM_WAYS];
  logic m_dirty [NUM_SETS][NUM_WAYS];
  tag_t m_tag   [NUM_SETS][NUM_WAYS];
  int   m_ptr   [NUM_SETS];

  tag_t tag_pool [3] = '{8'h11, 8'h22, 8'h33};

  llc_hit_miss uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic void model_clear();
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
      end
      m_ptr[s] = 0;
    end
  endfunction

  // returns {hit, way, evict, evict tag} and updates the mirror
  function automatic logic [11:0] predict(input addr_t addr, input logic rw);
    index_t idx;
    tag_t   tg;
    int     w;
    way_t   way;
    logic   evict;
    tag_t   old_tag;
    idx = addr[OFFSET_W +: INDEX_W];
    tg  = addr[OFFSET_W + INDEX_W +: TAG_W];
    w   = -1;
    way = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (m_valid[idx][i] && m_tag[idx][i] == tg) begin
        w = i;
      end
    end
    if (w >= 0) begin
      // hit, a write leaves the line dirty
      way[w]          = 1'b1;
      m_dirty[idx][w] = m_dirty[idx][w] | rw;
      return {1'b1, way, 1'b0, 8'h00};
    end
    // miss takes the round-robin victim
    w               = m_ptr[idx];
    way[w]          = 1'b1;
    evict           = m_valid[idx][w] & m_dirty[idx][w];
    old_tag         = m_tag[idx][w];
    m_valid[idx][w] = 1'b1;
    m_dirty[idx][w] = rw;
    m_tag[idx][w]   = tg;
    m_ptr[idx]      = (w + 1) % int'(NUM_WAYS);
    return {1'b0, way, evict, old_tag};
  endfunction

  function automatic addr_t mk_addr(input tag_t tg, input index_t idx,
                                    input logic [OFFSET_W-1:0] off);
    return {tg, idx, off};
  endfunction

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got == exp) else begin
      mismatch_cnt++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_fail(input string msg);
    fail_cnt++;
    $display("Error: %s", msg);
  endtask

  task automatic end_run();
    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  //////////////////////////////
  // stimulus and waits
  //////////////////////////////

  task automatic apply_reset();
    rst_n_i      = 1'b0;
    desc_valid_i = 1'b0;
    exp_q.delete();
    lock_q.delete();
    unlock_budget = 0;
    unlock_wait   = 0;
    model_clear();
    repeat (5) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
  endtask

  task automatic wait_init();
    int t;
    t = 0;
    while (!init_done_o && t < TIMEOUT) begin
      @(negedge clk_i);
      assert (init_done_o || !desc_ready_o)
        else report_fail("desc_ready_o high before init_done_o");
      t++;
    end
    if (init_done_o) begin
      @(posedge clk_i);
      #10;
    end else begin
      report_fail("timeout waiting for init_done_o");
      end_run();
    end
  endtask

  // the model runs at the acceptance edge, in acceptance order
  // ready is looked at mid-cycle, where it is stable
  task automatic send_desc(input addr_t addr, input logic rw);
    int t;
    t            = 0;
    desc_addr_i  = addr;
    desc_rw_i    = rw;
    desc_id_i    = next_id;
    desc_valid_i = 1'b1;
    while (!desc_ready_o && t < TIMEOUT) begin
      @(posedge clk_i);
      #10;
      t++;
    end
    if (desc_ready_o) begin
      @(posedge clk_i);
      exp_q.push_back({addr, rw, next_id, predict(addr, rw)});
      accepted++;
      next_id = next_id + id_t'(1);
      #10;
      desc_valid_i = 1'b0;
    end else begin
      report_fail("timeout waiting for desc_ready_o");
      end_run();
    end
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (done_cnt != accepted && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (done_cnt == accepted) begin
      @(posedge clk_i);
      #10;
    end else begin
      report_fail("timeout waiting for an output transfer");
      end_run();
    end
  endtask

  task automatic wait_unlocked();
    int t;
    t = 0;
    while (lock_q.size() > 0 && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (lock_q.size() == 0) begin
      @(posedge clk_i);
      #10;
    end else begin
      report_fail("timeout waiting for the locked lines to be released");
      end_run();
    end
  endtask

  // no valid may show while the stall lasts
  task automatic expect_stall(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      assert (!hit_valid_o && !miss_valid_o)
        else report_fail("output valid raised while the line is locked or the table is full");
    end
    @(posedge clk_i);
    #10;
  endtask

  task automatic release_locks(input int n);
    unlock_budget = unlock_budget + n;
  endtask

  //////////////////////////////
  // readies and unlocks
  //////////////////////////////

  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk_i);
      #20;
      r = $random(seed);
      hit_ready_i    = rand_mode ? (r[1:0] != 2'b00) : 1'b1;
      miss_ready_i   = rand_mode ? (r[3:2] != 2'b00) : 1'b1;
      unlock_valid_i = 1'b0;
      if (rst_n_i && lock_q.size() > 0 && (auto_unlock || unlock_budget > 0)) begin
        if (unlock_wait > 0) begin
          unlock_wait--;
        end else begin
          {unlock_index_i, unlock_way_i} = lock_q.pop_front();
          unlock_valid_i = 1'b1;
          if (!auto_unlock) begin
            unlock_budget--;
          end
          unlock_wait = rand_mode ? int'(r[6:4]) : 0;
        end
      end
    end
  end

  //////////////////////////////
  // output compare
  //////////////////////////////

  // sampled mid-cycle, the transfer happens at the following rising edge
  initial begin
    logic [32:0] e;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && ((hit_valid_o && hit_ready_i) || (miss_valid_o && miss_ready_i))) begin
        assert (exp_q.size() > 0) else report_fail("output transfer with no descriptor outstanding");
        if (exp_q.size() > 0) begin
          e = exp_q.pop_front();
          check_value("out_addr_o", out_addr_o, e[32:17]);
          check_value("out_rw_o", 16'(out_rw_o), 16'(e[16]));
          check_value("out_id_o", 16'(out_id_o), 16'(e[15:12]));
          check_value("hit_valid_o", 16'(hit_valid_o), 16'(e[11]));
          check_value("out_way_o", 16'(out_way_o), 16'(e[10:9]));
          check_value("out_evict_o", 16'(out_evict_o), 16'(e[8]));
          // victim tag only means something on a miss
          if (!e[11]) begin
            check_value("out_evict_tag_o", 16'(out_evict_tag_o), 16'(e[7:0]));
          end
        end
        lock_q.push_back({out_addr_o[OFFSET_W +: INDEX_W], out_way_o});
        last_hit       = hit_valid_o;
        last_way       = out_way_o;
        last_evict     = out_evict_o;
        last_evict_tag = out_evict_tag_o;
        done_cnt++;
      end
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    addr_t       a;
    way_t        first_way;
    logic [31:0] r;
    rst_n_i        = 1'b0;
    desc_addr_i    = '0;
    desc_rw_i      = 1'b0;
    desc_id_i      = '0;
    desc_valid_i   = 1'b0;
    hit_ready_i    = 1'b1;
    miss_ready_i   = 1'b1;
    unlock_index_i = '0;
    unlock_way_i   = '0;
    unlock_valid_i = 1'b0;
    mismatch_cnt   = 0;
    fail_cnt       = 0;
    accepted       = 0;
    done_cnt       = 0;
    auto_unlock    = 1'b1;
    rand_mode      = 1'b0;
    next_id        = '0;
    apply_reset();
    wait_init();

    // first touch of set 0 misses without eviction
    a = mk_addr(8'h11, 4'd0, 4'h3);
    send_desc(a, 1'b0);
    wait_idle();
    assert (!last_hit && !last_evict) else report_fail("first access to a set did not miss cleanly");
    first_way = last_way;
    // same tag hits its way, the write dirties the line
    send_desc(a, 1'b1);
    wait_idle();
    assert (last_hit && last_way == first_way) else report_fail("repeat access missed its way");
    // two new tags rotate through the ways and push out the dirty line
    send_desc(mk_addr(8'h22, 4'd0, 4'h0), 1'b0);
    wait_idle();
    assert (!last_hit && last_way != first_way) else report_fail("second tag reused the same way");
    send_desc(mk_addr(8'h33, 4'd0, 4'h8), 1'b0);
    wait_idle();
    assert (last_evict && last_evict_tag == 8'h11) else report_fail("dirty victim not evicted");

    // a locked line holds back the next descriptor to it
    wait_unlocked();
    auto_unlock = 1'b0;
    a = mk_addr(8'h44, 4'd2, 4'h0);
    send_desc(a, 1'b1);
    wait_idle();
    send_desc(a, 1'b0);
    expect_stall(8);
    release_locks(1);
    wait_idle();
    release_locks(1);
    wait_unlocked();

    // four held locks fill the table, the fifth descriptor waits
    for (int s = 4; s < 8; s++) begin
      send_desc(mk_addr(8'h55, index_t'(s), 4'h0), 1'b0);
      wait_idle();
    end
    send_desc(mk_addr(8'h55, 4'd8, 4'h0), 1'b0);
    expect_stall(8);
    release_locks(1);
    wait_idle();
    release_locks(LOCK_DEPTH);
    wait_unlocked();
    unlock_budget = 0;
    auto_unlock   = 1'b1;

    // random traffic over a few tags and sets
    rand_mode = 1'b1;
    repeat (RAND_DESCS) begin
      r = $random(seed);
      send_desc(mk_addr(tag_pool[int'(r[1:0]) % 3], {2'b00, r[5:4]}, r[11:8]), r[12]);
    end
    wait_idle();
    rand_mode = 1'b0;
    wait_unlocked();

    // a reset in mid-run drops a line that hit before
    a = mk_addr(8'h66, 4'd9, 4'h0);
    send_desc(a, 1'b0);
    wait_idle();
    send_desc(a, 1'b0);
    wait_idle();
    assert (last_hit) else report_fail("repeat access before reset did not hit");
    wait_unlocked();
    apply_reset();
    wait_init();
    send_desc(a, 1'b0);
    wait_idle();
    assert (!last_hit && !last_evict) else report_fail("line survived the mid-run reset");
    wait_unlocked();
    end_run();
  end

endmodule

/* verilog/llc_hit_miss.sv */
module llc_hit_miss (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  llc_pkg::addr_t  desc_addr_i,
  input  logic            desc_rw_i,
  input  llc_pkg::id_t    desc_id_i,
  input  logic            desc_valid_i,
  output logic            desc_ready_o,
  output llc_pkg::addr_t  out_addr_o,
  output logic            out_rw_o,
  output llc_pkg::id_t    out_id_o,
  output llc_pkg::way_t   out_way_o,
  output logic            out_evict_o,
  output llc_pkg::tag_t   out_evict_tag_o,
  output logic            hit_valid_o,
  input  logic            hit_ready_i,
  output logic            miss_valid_o,
  input  logic            miss_ready_i,
  input  llc_pkg::index_t unlock_index_i,
  input  llc_pkg::way_t   unlock_way_i,
  input  logic            unlock_valid_i,
  output logic            init_done_o
);
  import llc_pkg::*;

  // control state
  // busy spans acceptance to transfer, held spans result capture to transfer
  logic   busy_q;
  logic   held_q;
  logic   out_hit_q;

  // handshakes
  logic   desc_fire;
  logic   out_fire;

  // tag store request and result
  index_t req_index;
  tag_t   req_tag;
  logic   res_valid;
  way_t   res_way;
  logic   res_hit;
  logic   res_evict;
  tag_t   res_evict_tag;

  // lock table
  index_t out_index;
  logic   locked;
  logic   lock_full;
  logic   stall;

  //////////////////////////////
  // input side
  //////////////////////////////

  // one descriptor in flight, nothing enters before the clear sweep ends
  assign desc_ready_o = init_done_o & ~busy_q;
  assign desc_fire    = desc_valid_i & desc_ready_o;

  // address split {tag, index, offset}
  assign req_index = desc_addr_i[OFFSET_W +: INDEX_W];
  assign req_tag   = desc_addr_i[OFFSET_W + INDEX_W +: TAG_W];

  llc_tag_store u_tag_store (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .req_valid_i     ( desc_fire     ),
    .req_index_i     ( req_index     ),
    .req_tag_i       ( req_tag       ),
    .req_dirty_i     ( desc_rw_i     ),
    .res_valid_o     ( res_valid     ),
    .res_way_o       ( res_way       ),
    .res_hit_o       ( res_hit       ),
    .res_evict_o     ( res_evict     ),
    .res_evict_tag_o ( res_evict_tag ),
    .init_done_o     ( init_done_o   )
  );

  //////////////////////////////
  // output side
  //////////////////////////////

  // hold off while the line is in use downstream or no lock slot is free
  assign out_index = out_addr_o[OFFSET_W +: INDEX_W];
  assign stall     = locked | lock_full;

  assign hit_valid_o  = held_q & ~stall &  out_hit_q;
  assign miss_valid_o = held_q & ~stall & ~out_hit_q;
  assign out_fire     = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);

  // every transfer locks its line in the same edge
  llc_lock_table u_lock_table (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .lock_valid_i   ( out_fire       ),
    .lock_index_i   ( out_index      ),
    .lock_way_i     ( out_way_o      ),
    .unlock_valid_i ( unlock_valid_i ),
    .unlock_index_i ( unlock_index_i ),
    .unlock_way_i   ( unlock_way_i   ),
    .query_index_i  ( out_index      ),
    .query_way_i    ( out_way_o      ),
    .locked_o       ( locked         ),
    .full_o         ( lock_full      )
  );

  // accept and transfer never fall in the same cycle, busy guards that
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      held_q <= 1'b0;
    end else begin
      if (desc_fire) begin
        busy_q <= 1'b1;
      end else if (out_fire) begin
        busy_q <= 1'b0;
      end
      // store answers exactly one cycle after the request
      if (res_valid) begin
        held_q <= 1'b1;
      end else if (out_fire) begin
        held_q <= 1'b0;
      end
    end
  end

  // descriptor fields and lookup result, all stay put until the transfer
  // reset keeps the outputs low
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_addr_o      <= '0;
      out_rw_o        <= 1'b0;
      out_id_o        <= '0;
      out_way_o       <= '0;
      out_hit_q       <= 1'b0;
      out_evict_o     <= 1'b0;
      out_evict_tag_o <= '0;
    end else begin
      if (desc_fire) begin
        out_addr_o <= desc_addr_i;
        out_rw_o   <= desc_rw_i;
        out_id_o   <= desc_id_i;
      end
      if (res_valid) begin
        out_way_o       <= res_way;
        out_hit_q       <= res_hit;
        out_evict_o     <= res_evict;
        out_evict_tag_o <= res_evict_tag;
      end
    end
  end

endmodule

/* verilog/llc_lock_table.sv */
module llc_lock_table (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            lock_valid_i,
  input  llc_pkg::index_t lock_index_i,
  input  llc_pkg::way_t   lock_way_i,
  input  logic            unlock_valid_i,
  input  llc_pkg::index_t unlock_index_i,
  input  llc_pkg::way_t   unlock_way_i,
  input  llc_pkg::index_t query_index_i,
  input  llc_pkg::way_t   query_way_i,
  output logic            locked_o,
  output logic            full_o
);
  import llc_pkg::*;

  // entry storage
  logic [LOCK_DEPTH-1:0] ent_valid_q;
  index_t                ent_index_q [LOCK_DEPTH];
  way_t                  ent_way_q   [LOCK_DEPTH];

  // one-hot pick of the lowest free entry
  logic [LOCK_DEPTH-1:0] free_sel;
  // entries hit by the unlock or by the query
  logic [LOCK_DEPTH-1:0] unlock_match;
  logic [LOCK_DEPTH-1:0] query_match;

  //////////////////////////////
  // entry matching
  //////////////////////////////

  always_comb begin
    logic found;
    found    = 1'b0;
    free_sel = '0;
    for (int i = 0; i < LOCK_DEPTH; i++) begin
      if (!ent_valid_q[i] && !found) begin
        free_sel[i] = 1'b1;
        found       = 1'b1;
      end
    end
  end

  // both compares look at the same (index, way) pair of each entry
  always_comb begin
    for (int i = 0; i < LOCK_DEPTH; i++) begin
      unlock_match[i] = ent_valid_q[i] && (ent_index_q[i] == unlock_index_i) &&
                        (ent_way_q[i] == unlock_way_i);
      query_match[i]  = ent_valid_q[i] && (ent_index_q[i] == query_index_i) &&
                        (ent_way_q[i] == query_way_i);
    end
  end

  assign locked_o = |query_match;
  assign full_o   = &ent_valid_q;

  //////////////////////////////
  // table update
  //////////////////////////////

  // insert only hits a free slot and unlock only a used one, so no overlap
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ent_valid_q <= '0;
    end else begin
      for (int i = 0; i < LOCK_DEPTH; i++) begin
        if (lock_valid_i && free_sel[i]) begin
          ent_valid_q[i] <= 1'b1;
        end else if (unlock_valid_i && unlock_match[i]) begin
          ent_valid_q[i] <= 1'b0;
        end
      end
    end
  end

  // line address of each entry
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < LOCK_DEPTH; i++) begin
      if (lock_valid_i && free_sel[i]) begin
        ent_index_q[i] <= lock_index_i;
        ent_way_q[i]   <= lock_way_i;
      end
    end
  end

endmodule

/* verilog/llc_pkg.sv */
package llc_pkg;

  //////////////////////////////
  // cache geometry
  //////////////////////////////

  // descriptor address width
  localparam int unsigned ADDR_W     = 16;
  // byte offset inside one cache line
  localparam int unsigned OFFSET_W   = 4;
  // set index bits, sit right above the offset
  localparam int unsigned INDEX_W    = 4;
  // tag bits, top of the address
  localparam int unsigned TAG_W      = 8;
  // one set per index value
  localparam int unsigned NUM_SETS   = 16;
  // two-way set associative
  localparam int unsigned NUM_WAYS   = 2;
  // number of lines that can be locked downstream at once
  localparam int unsigned LOCK_DEPTH = 4;
  // transaction id width
  localparam int unsigned ID_W       = 4;

  //////////////////////////////
  // field types
  //////////////////////////////

  // full descriptor address, split as {tag, index, offset}
  typedef logic [ADDR_W-1:0]   addr_t;

  // set index
  typedef logic [INDEX_W-1:0]  index_t;

  // stored tag
  typedef logic [TAG_W-1:0]    tag_t;

  // one-hot way indicator
  typedef logic [NUM_WAYS-1:0] way_t;

  // transaction id carried through unchanged
  typedef logic [ID_W-1:0]     id_t;

endpackage

/* verilog/llc_tag_store.sv */
module llc_tag_store (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            req_valid_i,
  input  llc_pkg::index_t req_index_i,
  input  llc_pkg::tag_t   req_tag_i,
  input  logic            req_dirty_i,
  output logic            res_valid_o,
  output llc_pkg::way_t   res_way_o,
  output logic            res_hit_o,
  output logic            res_evict_o,
  output llc_pkg::tag_t   res_evict_tag_o,
  output logic            init_done_o
);
  import llc_pkg::*;

  // per set state, kept in flops
  logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
  logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
  tag_t                tag_q   [NUM_SETS][NUM_WAYS];
  // one-hot round-robin victim pointer per set
  way_t                rr_q    [NUM_SETS];

  // clear sweep after reset
  index_t init_cnt_q;
  logic   init_done_q;

  // lookup results, combinational on the request
  way_t   hit_way;
  logic   lookup_hit;
  way_t   victim_way;
  logic   victim_valid;
  logic   victim_dirty;
  tag_t   victim_tag;

  //////////////////////////////
  // init sweep
  //////////////////////////////

  // walk through all sets once, one per cycle
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      init_cnt_q  <= '0;
      init_done_q <= 1'b0;
    end else if (!init_done_q) begin
      init_cnt_q <= init_cnt_q + index_t'(1);
      // last set cleared this edge
      if (init_cnt_q == index_t'(NUM_SETS - 1)) begin
        init_done_q <= 1'b1;
      end
    end
  end

  assign init_done_o = init_done_q;

  //////////////////////////////
  // lookup
  //////////////////////////////

  // compare the tag against every valid way of the set
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_way[w] = valid_q[req_index_i][w] && (tag_q[req_index_i][w] == req_tag_i);
    end
  end

  assign lookup_hit = |hit_way;
  assign victim_way = rr_q[req_index_i];

  // state of the line the pointer selects
  always_comb begin
    victim_valid = 1'b0;
    victim_dirty = 1'b0;
    victim_tag   = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim_way[w]) begin
        victim_valid = valid_q[req_index_i][w];
        victim_dirty = dirty_q[req_index_i][w];
        victim_tag   = tag_q[req_index_i][w];
      end
    end
  end

  // array update, either the clear sweep or the lookup write-back
  always_ff @(posedge clk_i) begin
    if (!init_done_q) begin
      valid_q[init_cnt_q] <= '0;
      dirty_q[init_cnt_q] <= '0;
      rr_q[init_cnt_q]    <= way_t'(1);
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_q[init_cnt_q][w] <= '0;
      end
    end else if (req_valid_i) begin
      if (lookup_hit) begin
        // a write marks the hit line dirty, a read leaves it
        dirty_q[req_index_i] <= dirty_q[req_index_i] | (hit_way & {NUM_WAYS{req_dirty_i}});
      end else begin
        // allocate the victim way with the new tag
        valid_q[req_index_i] <= valid_q[req_index_i] | victim_way;
        if (req_dirty_i) begin
          dirty_q[req_index_i] <= dirty_q[req_index_i] | victim_way;
        end else begin
          dirty_q[req_index_i] <= dirty_q[req_index_i] & ~victim_way;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (victim_way[w]) begin
            tag_q[req_index_i][w] <= req_tag_i;
          end
        end
        // rotate the one-hot pointer
        rr_q[req_index_i] <= {victim_way[NUM_WAYS-2:0], victim_way[NUM_WAYS-1]};
      end
    end
  end

  //////////////////////////////
  // result register
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= req_valid_i;
    end
  end

  // payload only follows a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      res_way_o       <= lookup_hit ? hit_way : victim_way;
      res_hit_o       <= lookup_hit;
      res_evict_o     <= ~lookup_hit & victim_valid & victim_dirty;
      res_evict_tag_o <= lookup_hit ? tag_t'(0) : victim_tag;
    end
  end

endmodule
